//--- filelist.f
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/reg_file.sv
verilog/alu_lane.sv
verilog/operand_bypass.sv
verilog/issue_ctrl.sv
verilog/dual_issue_top.sv
dv/dual_issue_assert.sv
dv/dual_issue_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := dual_issue_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/dual_issue_tb.sv
`timescale 1ns/10ps

module dual_issue_tb import rv_isa_pkg::*, pipe_pkg::*; ();

  localparam logic [6:0] f7_sub = 7'b0100000;

  typedef struct packed {
    instr_t a;
    instr_t b;
    xword_t exp_a;
    xword_t exp_b;
    logic   split;  // b reads a's rd, so hold goes high once
  } row_t;

  typedef struct packed {
    logic      lane;  // 0 lane a, 1 lane b
    reg_addr_t rd;
    xword_t    data;
    int        due;   // cycle count at the negedge where it must show
  } exp_t;

  logic        clk;
  logic        arst_n;
  logic        pair_valid;
  instr_t      instr_a, instr_b;
  logic        hold;
  lane_res_t   wb_a, wb_b;

  row_t        rows[$];
  exp_t        expected[$];
  logic [19:0] lfsr;
  int          cycles;
  int          timeout_limit;
  int          checks, errors, split_errors;

  dual_issue_top dual_issue_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .pair_valid (pair_valid),
    .instr_a    (instr_a),
    .instr_b    (instr_b),
    .hold       (hold),
    .wb_a       (wb_a),
    .wb_b       (wb_b)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // encoding helpers and stimulus table
  // ------------------------------------------------------------
  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
  endfunction

  function automatic instr_t enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                   input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), opc_op_imm};
  endfunction

  task automatic add_row(input instr_t a, input instr_t b, input xword_t exp_a,
                         input xword_t exp_b, input logic split);
    rows.push_back('{a, b, exp_a, exp_b, split});
  endtask

  task automatic build_table();
    add_row(enc_i(f3_add_sub, 1, 0, 12'd5), enc_i(f3_add_sub, 2, 0, 12'hFFD),
            64'h5, 64'hFFFF_FFFF_FFFF_FFFD, 1'b0);
    add_row(enc_r(7'd0, f3_add_sub, 3, 1, 2), enc_r(f7_sub, f3_add_sub, 4, 1, 2),
            64'h2, 64'h8, 1'b0);
    add_row(enc_i(f3_sll, 5, 1, 12'd4), enc_r(7'd0, f3_add_sub, 6, 5, 3),
            64'h50, 64'h52, 1'b1);
    add_row(enc_r(7'd0, f3_slt, 7, 2, 1), enc_r(7'd0, f3_slt, 8, 1, 2),
            64'h1, 64'h0, 1'b0);
    add_row(enc_i(f3_srl, 9, 2, 12'd60), enc_i(f3_xor, 10, 1, 12'hFFF),
            64'hF, 64'hFFFF_FFFF_FFFF_FFFA, 1'b0);
    add_row(enc_i(f3_add_sub, 11, 0, 12'h7FF), enc_i(f3_add_sub, 11, 0, 12'h800),
            64'h7FF, 64'hFFFF_FFFF_FFFF_F800, 1'b0);  // same rd in both lanes
    add_row(enc_r(7'd0, f3_add_sub, 12, 11, 0), enc_r(7'd0, f3_or, 13, 9, 7),
            64'hFFFF_FFFF_FFFF_F800, 64'hF, 1'b0);
    add_row(enc_r(7'd0, f3_and, 14, 10, 5), enc_i(f3_add_sub, 0, 14, 12'd1),
            64'h50, 64'h0, 1'b1);                     // b targets x0
    add_row({20'h12345, 5'd15, 7'b0110111}, enc_r(7'd0, f3_add_sub, 16, 15, 12),
            64'h0, 64'hFFFF_FFFF_FFFF_F800, 1'b0);    // lui is a bubble
    add_row(enc_i(f3_add_sub, 17, 1, 12'd1), {12'd0, 5'd1, 3'b011, 5'd17, 7'b0000011},
            64'h6, 64'h0, 1'b0);                      // load is a bubble
    add_row(enc_r(7'd0, f3_add_sub, 18, 17, 17), enc_r(7'd0, f3_sll, 19, 1, 13),
            64'hC, 64'h28000, 1'b0);
    add_row(enc_r(7'd0, f3_srl, 20, 19, 1), enc_r(f7_sub, f3_add_sub, 21, 20, 18),
            64'h1400, 64'h13F4, 1'b1);
    add_row(enc_i(f3_slt, 22, 21, 12'hFFF), enc_i(f3_slt, 23, 2, 12'hFFE),
            64'h0, 64'h1, 1'b0);
    add_row(enc_i(f3_and, 24, 2, 12'h0F0), enc_i(f3_or, 25, 0, 12'hFF0),
            64'hF0, 64'hFFFF_FFFF_FFFF_FFF0, 1'b0);
    add_row(enc_r(7'd0, f3_xor, 26, 24, 25), enc_r(7'd0, f3_add_sub, 0, 1, 1),
            64'hFFFF_FFFF_FFFF_FF00, 64'h0, 1'b0);
    add_row(enc_r(7'd0, f3_add_sub, 1, 1, 1), enc_r(7'd0, f3_add_sub, 2, 1, 2),
            64'hA, 64'h7, 1'b1);
    add_row(enc_r(f7_sub, f3_add_sub, 27, 0, 1), enc_i(f3_srl, 28, 27, 12'd4),
            64'hFFFF_FFFF_FFFF_FFF6, 64'h0FFF_FFFF_FFFF_FFFF, 1'b1);
    add_row(enc_r(7'd0, f3_or, 29, 0, 26), enc_r(7'd0, f3_slt, 30, 27, 0),
            64'hFFFF_FFFF_FFFF_FF00, 64'h1, 1'b0);
    add_row(enc_i(f3_add_sub, 31, 2, 12'd100), enc_i(f3_add_sub, 31, 28, 12'd1),
            64'h6B, 64'h1000_0000_0000_0000, 1'b0);
    add_row(enc_r(7'd0, f3_add_sub, 5, 31, 0), enc_r(f7_sub, f3_add_sub, 6, 31, 3),
            64'h1000_0000_0000_0000, 64'h0FFF_FFFF_FFFF_FFFE, 1'b0);
  endtask

  // ------------------------------------------------------------
  // expected results and gap source
  // ------------------------------------------------------------
  function automatic logic writes_rd(input instr_t instr);
    return ((instr[6:0] == opc_op) || (instr[6:0] == opc_op_imm)) && (instr[11:7] != '0);
  endfunction

  task automatic expect_result(input logic lane, input instr_t instr, input xword_t data,
                               input int due);
    if (writes_rd(instr)) begin
      expected.push_back('{lane, instr[11:7], data, due});
    end
  endtask

  function automatic logic [19:0] lfsr_step(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};  // taps 20 and 17
  endfunction

  task automatic next_gap(output logic [1:0] gap);
    gap = 2'b00;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      gap  = {gap[0], lfsr[0]};
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [1:0] gap;
    int         due;
    arst_n     <= 1'b0;
    pair_valid <= 1'b0;
    instr_a    <= '0;
    instr_b    <= '0;
    lfsr        = 20'd98492;
    build_table();
    timeout_limit = rows.size() * 6 + 40;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < rows.size(); r++) begin
      pair_valid <= 1'b1;
      instr_a    <= rows[r].a;
      instr_b    <= rows[r].b;
      @(negedge clk);
      due = cycles + 2;  // accepted at the next edge, result reg one edge later
      expect_result(1'b0, rows[r].a, rows[r].exp_a, due);
      if (hold != rows[r].split) begin
        split_errors++;
        $display("FAILED %0t: row %0d hold %b, expected %b", $time, r, hold, rows[r].split);
      end
      if (hold) begin
        @(negedge clk);
        due++;           // b goes one edge after a
        if (hold) begin
          split_errors++;
          $display("FAILED %0t: row %0d hold high for a second cycle", $time, r);
        end
      end
      expect_result(1'b1, rows[r].b, rows[r].exp_b, due);
      next_gap(gap);
      @(posedge clk);
      repeat (gap) begin
        pair_valid <= 1'b0;
        @(posedge clk);
      end
    end
    pair_valid <= 1'b0;
    while (expected.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // late or extra results would show here
    $display("result checks %0d, result errors %0d, split errors %0d",
             checks, errors, split_errors);
    if ((errors == 0) && (split_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ------------------------------------------------------------
  // result checks
  // ------------------------------------------------------------
  task automatic check_result(input logic lane, input lane_res_t res);
    exp_t e;
    checks++;
    if (expected.size() == 0) begin
      errors++;
      $display("unexpected result on lane %0d for x%0d at %0t", lane, res.rd, $time);
    end else begin
      e = expected.pop_front();
      if ((e.lane != lane) || (e.rd != res.rd) || (e.data != res.data) || (e.due != cycles)) begin
        errors++;
        $display("FAILED %0t: lane %0d x%0d = %h at cycle %0d, expected lane %0d x%0d = %h at %0d",
                 $time, lane, res.rd, res.data, cycles, e.lane, e.rd, e.data, e.due);
      end
    end
  endtask

  always @(negedge clk) begin
    if (!arst_n) begin
      if (hold || wb_a.valid || wb_b.valid) begin
        errors++;
        $display("FAILED %0t: hold or wb valid high during reset", $time);
      end
    end else begin
      if (hold && !pair_valid) begin
        errors++;
        $display("FAILED %0t: hold high with no pair on the inputs", $time);
      end
      if (wb_a.valid) check_result(1'b0, wb_a);  // older lane first
      if (wb_b.valid) check_result(1'b1, wb_b);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout after %0d cycles with %0d results still missing",
               cycles, expected.size());
      $display("result checks %0d, result errors %0d, split errors %0d",
               checks, errors, split_errors);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

//--- dv/dual_issue_assert.sv
`timescale 1ns/10ps

module dual_issue_assert import pipe_pkg::*; (
  input logic      clk,
  input logic      arst_n,
  input logic      pair_valid,
  input logic      hold,
  input lane_res_t wb_a,
  input lane_res_t wb_b
);

  // a split only holds a pair that is on the inputs
  hold_needs_pair: assert property (@(posedge clk) disable iff (!arst_n) hold |-> pair_valid)
    else $error("hold high without pair_valid");

  hold_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) hold |=> !hold)
    else $error("hold high for two cycles in a row");

  // x0 targets are dropped before writeback
  wb_a_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    wb_a.valid |-> (wb_a.rd != '0)) else $error("wb_a valid with rd x0");

  wb_b_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    wb_b.valid |-> (wb_b.rd != '0)) else $error("wb_b valid with rd x0");

endmodule

bind dual_issue_top dual_issue_assert dual_issue_assert_i (
  .clk(clk), .arst_n(arst_n), .pair_valid(pair_valid), .hold(hold), .wb_a(wb_a), .wb_b(wb_b)
);

//--- verilog/dual_issue_top.sv
`timescale 1ns/10ps

module dual_issue_top import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      pair_valid,
  input  instr_t    instr_a,  // older of the pair
  input  instr_t    instr_b,
  output logic      hold,
  output lane_res_t wb_a,
  output lane_res_t wb_b
);

  reg_addr_t [3:0] rs_addr, rf_addr;
  xword_t    [3:0] rs_val, rf_data;
  xword_t    [1:0] exec_res;
  issue_pair_t     issue_d, issue_q;
  lane_res_t       res_a, res_b;
  res_pair_t       res_d, res_q;

  // ------------------------------------------------------------
  // decode / operand read
  // ------------------------------------------------------------
  issue_ctrl issue_ctrl_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .pair_valid (pair_valid),
    .instr_a    (instr_a),
    .instr_b    (instr_b),
    .rs_addr    (rs_addr),
    .rs_val     (rs_val),
    .hold       (hold),
    .issue      (issue_d)
  );

  operand_bypass operand_bypass_i (
    .rs_addr  (rs_addr),
    .exec_ops (issue_q),
    .exec_res (exec_res),
    .wb       (res_q),
    .rf_addr  (rf_addr),
    .rf_data  (rf_data),
    .rs_val   (rs_val)
  );

  reg_file reg_file_i (.clk(clk), .arst_n(arst_n), .rd_addr(rf_addr), .rd_data(rf_data), .wr(res_q));

  stage_reg #(.payload_t(issue_pair_t)) issue_reg_i (
    .clk(clk), .arst_n(arst_n), .d(issue_d), .q(issue_q)
  );

  // ------------------------------------------------------------
  // execute / writeback
  // ------------------------------------------------------------
  alu_lane alu_a_i (.op(issue_q.a), .res(res_a));
  alu_lane alu_b_i (.op(issue_q.b), .res(res_b));

  assign exec_res = {res_b.data, res_a.data};
  assign res_d    = '{a: res_a, b: res_b};

  stage_reg #(.payload_t(res_pair_t)) res_reg_i (
    .clk(clk), .arst_n(arst_n), .d(res_d), .q(res_q)
  );

  assign wb_a = res_q.a;
  assign wb_b = res_q.b;

endmodule

//--- verilog/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  pair_valid,
  input  instr_t                instr_a,
  input  instr_t                instr_b,
  output reg_addr_t [3:0]       rs_addr,  // a.rs1, a.rs2, b.rs1, b.rs2
  input  xword_t    [3:0]       rs_val,
  output logic                  hold,
  output issue_pair_t           issue
);

  lane_op_t op_a, op_b;
  logic     dep;
  logic     split_q;  // a already went, b is next

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  function automatic lane_op_t decode(input instr_t instr);
    lane_op_t op;
    logic     ok;
    op         = '0;
    ok         = (instr[6:0] == opc_op) || (instr[6:0] == opc_op_imm);
    op.rd      = instr[11:7];
    op.use_imm = (instr[6:0] == opc_op_imm);
    if (op.use_imm) begin
      op.imm = instr[31:20];
    end
    case (instr[14:12])
      f3_add_sub: op.alu_op = (instr[30] && !op.use_imm) ? alu_sub : alu_add;
      f3_sll:     op.alu_op = alu_sll;
      f3_slt:     op.alu_op = alu_slt;
      f3_xor:     op.alu_op = alu_xor;
      f3_srl: begin
        op.alu_op = alu_srl;
        ok        = ok && !instr[30];  // no arithmetic shift
      end
      f3_or:      op.alu_op = alu_or;
      f3_and:     op.alu_op = alu_and;
      default:    ok = 1'b0;           // sltu / sltiu
    endcase
    op.wr_en = ok && (op.rd != '0);
    return op;
  endfunction

  assign op_a = decode(instr_a);
  assign op_b = decode(instr_b);

  assign rs_addr = {instr_b[24:20], instr_b[19:15], instr_a[24:20], instr_a[19:15]};

  // b needs a's result
  // rs2 only counts for register-register ops
  assign dep = op_a.wr_en &&
               (((instr_b[6:0] == opc_op) || (instr_b[6:0] == opc_op_imm)) &&
                (instr_b[19:15] == op_a.rd) ||
                (instr_b[6:0] == opc_op) && (instr_b[24:20] == op_a.rd));

  assign hold = pair_valid && dep && !split_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      split_q <= 1'b0;
    end else begin
      split_q <= hold;  // one cycle only
    end
  end

  // ------------------------------------------------------------
  // issued pair
  // ------------------------------------------------------------
  always_comb begin
    issue           = '{a: op_a, b: op_b};
    issue.a.valid   = pair_valid && !split_q;
    issue.b.valid   = pair_valid && (split_q || !dep);
    issue.a.rs1_val = rs_val[0];
    issue.a.rs2_val = rs_val[1];
    issue.b.rs1_val = rs_val[2];
    issue.b.rs2_val = rs_val[3];
  end

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass import rv_isa_pkg::*, pipe_pkg::*; (
  input  reg_addr_t [3:0] rs_addr,
  input  issue_pair_t     exec_ops,
  input  xword_t    [1:0] exec_res,  // [0] lane a, [1] lane b
  input  res_pair_t       wb,
  output reg_addr_t [3:0] rf_addr,
  input  xword_t    [3:0] rf_data,
  output xword_t    [3:0] rs_val
);

  src_sel_e sel [4];
  logic     exec_a_wr, exec_b_wr;

  function automatic logic hit(input logic vld, input reg_addr_t rd, input reg_addr_t addr);
    return vld && (rd == addr) && (addr != '0);
  endfunction

  assign exec_a_wr = exec_ops.a.valid && exec_ops.a.wr_en;
  assign exec_b_wr = exec_ops.b.valid && exec_ops.b.wr_en;

  assign rf_addr = rs_addr;

  // ------------------------------------------------------------
  // source select, youngest first, lane b before lane a
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (hit(exec_b_wr, exec_ops.b.rd, rs_addr[i])) begin
        sel[i] = src_exec_b;
      end else if (hit(exec_a_wr, exec_ops.a.rd, rs_addr[i])) begin
        sel[i] = src_exec_a;
      end else if (hit(wb.b.valid, wb.b.rd, rs_addr[i])) begin
        sel[i] = src_wb_b;
      end else if (hit(wb.a.valid, wb.a.rd, rs_addr[i])) begin
        sel[i] = src_wb_a;
      end else begin
        sel[i] = src_rf;
      end

      case (sel[i])
        src_exec_b: rs_val[i] = exec_res[1];
        src_exec_a: rs_val[i] = exec_res[0];
        src_wb_b:   rs_val[i] = wb.b.data;
        src_wb_a:   rs_val[i] = wb.a.data;
        default:    rs_val[i] = rf_data[i];  // x0 comes back as zero here
      endcase
    end
  end

endmodule

//--- verilog/alu_lane.sv
`timescale 1ns/10ps

module alu_lane import rv_isa_pkg::*, pipe_pkg::*; (
  input  lane_op_t  op,
  output lane_res_t res
);

  xword_t                    opa, opb, y;
  logic [$clog2(xlen)-1:0]   shamt;

  // ------------------------------------------------------------
  // operand select
  // ------------------------------------------------------------
  assign opa   = op.rs1_val;
  assign opb   = op.use_imm ? {{(xlen-imm_w){op.imm[imm_w-1]}}, op.imm}  // sign extend
                            : op.rs2_val;
  assign shamt = opb[$clog2(xlen)-1:0];

  // ------------------------------------------------------------
  // 64-bit alu
  // ------------------------------------------------------------
  always_comb begin
    case (op.alu_op)
      alu_add: y = opa + opb;
      alu_sub: y = opa - opb;
      alu_sll: y = opa << shamt;
      alu_srl: y = opa >> shamt;
      alu_slt: y = {{(xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
      alu_xor: y = opa ^ opb;
      alu_or:  y = opa | opb;
      alu_and: y = opa & opb;
      default: y = '0;
    endcase
  end

  // bubbles and x0 targets give no result
  assign res = '{valid: op.valid && op.wr_en, rd: op.rd, data: y};

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  reg_addr_t [3:0] rd_addr,
  output xword_t    [3:0] rd_data,
  input  res_pair_t       wr
);

  xword_t regs [2**reg_addr_w];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < 2**reg_addr_w; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wr.a.valid && (wr.a.rd != '0)) begin
        regs[wr.a.rd] <= wr.a.data;
      end
      if (wr.b.valid && (wr.b.rd != '0)) begin
        regs[wr.b.rd] <= wr.b.data;  // later in program order, wins on same rd
      end
    end
  end

  // combinational read, x0 hardwired
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rd_data[i] = (rd_addr[i] == '0) ? '0 : regs[rd_addr[i]];
    end
  end

endmodule

//--- verilog/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t d,
  output payload_t q
);

  // pipeline register between two stages
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;  // every valid bit in the payload drops
    end else begin
      q <= d;
    end
  end

endmodule

//--- verilog/pipe_pkg.sv
package pipe_pkg;
  import rv_isa_pkg::*;

  // one decoded instruction with its forwarded operands
  typedef struct packed {
    logic             valid;
    alu_op_e          alu_op;
    logic             use_imm;  // operand b from imm instead of rs2
    logic [imm_w-1:0] imm;
    reg_addr_t        rd;
    logic             wr_en;    // low for bubbles and x0 targets
    xword_t           rs1_val;
    xword_t           rs2_val;
  } lane_op_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xword_t    data;
  } lane_res_t;

  typedef struct packed {
    lane_op_t a;
    lane_op_t b;
  } issue_pair_t;

  typedef struct packed {
    lane_res_t a;
    lane_res_t b;
  } res_pair_t;

  typedef enum logic [2:0] {src_rf, src_exec_a, src_exec_b, src_wb_a, src_wb_b} src_sel_e;

endpackage

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int unsigned xlen       = 64;
  localparam int unsigned instr_w    = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned imm_w      = 12;

  // ------------------------------------------------------------
  // major opcodes and funct3 codes
  // ------------------------------------------------------------
  localparam logic [6:0] opc_op     = 7'b0110011; // register-register
  localparam logic [6:0] opc_op_imm = 7'b0010011; // register-immediate

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_srl,
    alu_slt, alu_xor, alu_or,  alu_and
  } alu_op_e;

  typedef logic [instr_w-1:0]    instr_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [xlen-1:0]       xword_t;

endpackage
